//--- dv/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
#(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 8
)
(
    input  wire  i_rst_req,     // restarts the reset sequence
    output logic o_clk,
    output logic o_rst
);

    int rst_left = RST_CYCLES;  // rising edges still to see reset

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    always @(posedge o_clk)
    begin
        if (i_rst_req)
            rst_left <= RST_CYCLES;
        else if (rst_left != 0)
            rst_left <= rst_left - 1;
    end

    assign o_rst = (rst_left != 0);

endmodule

`default_nettype wire

//--- dv/tb_stretch_reflex.sv
`timescale 1ns/1ps
`default_nettype none

`include "stretch_reflex_consts.svh"

module tb_stretch_reflex;

    localparam int          PERIOD_MAX     = 32;    // longest period any test loads
    localparam int          TIMEOUT_CYCLES = 60 * PERIOD_MAX + 200;
    localparam int unsigned SEED           = 32'h2837e074;
    localparam longint      V_MAX          = (64'sd1 <<< (`SR_V_W - 1)) - 1;
    localparam longint      V_MIN          = -V_MAX - 1;
    localparam logic [`SR_WORD_W-1:0] BIG_SAMPLE = 16'h4000;

    wire                    ep50trig;
    wire                    reset_global;
    logic                   rst_req;
    logic                   i_sim_reset;
    logic [15:0]            i_trig;
    logic [`SR_WORD_W-1:0]  i_wire_lo;
    logic [`SR_WORD_W-1:0]  i_wire_hi;
    logic                   i_pipe_write;
    logic [`SR_WORD_W-1:0]  i_pipe_data;
    wire  [`SR_WORD_W-1:0]  o_sample;
    wire                    o_feed_done;
    wire                    o_step_valid;
    wire                    o_ia_spike;
    wire                    o_ii_spike;
    wire                    o_mn_spike;
    wire  [`SR_PARAM_W-1:0] o_mn_count;

    // reference model state
    longint                v_exp [0:2];
    logic [`SR_WORD_W-1:0] wave [$];         // samples in write order
    logic [`SR_WORD_W-1:0] smp_exp;
    int                    play_idx;
    bit                    play_on;
    bit                    ia_exp;
    bit                    ii_exp;
    bit                    mn_exp;
    int                    mn_total;
    longint                coef_ia_m;
    longint                coef_ii_m;
    longint                gain_mn_m;
    longint                thresh_m;
    longint                leak_m;

    int    cycle_cnt = 0;
    int    last_step_cyc = 0;
    int    step_gap = 0;
    int    ia_seen;
    int    ii_seen;
    int    mn_seen;
    int    err_cnt = 0;
    int    check_cnt = 0;
    int    test_cnt = 0;
    int    fail_cnt = 0;
    int    test_err0;
    string test_name;

    tb_clkgen #(.PERIOD_NS(100), .RST_CYCLES(8)) u_clkgen
    (
        .i_rst_req (rst_req),
        .o_clk     (ep50trig),
        .o_rst     (reset_global)
    );

    stretch_reflex_top UUT
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_trig       (i_trig),
        .i_wire_lo    (i_wire_lo),
        .i_wire_hi    (i_wire_hi),
        .i_pipe_write (i_pipe_write),
        .i_pipe_data  (i_pipe_data),
        .o_sample     (o_sample),
        .o_feed_done  (o_feed_done),
        .o_step_valid (o_step_valid),
        .o_ia_spike   (o_ia_spike),
        .o_ii_spike   (o_ii_spike),
        .o_mn_spike   (o_mn_spike),
        .o_mn_count   (o_mn_count)
    );

    always @(posedge ep50trig)
        cycle_cnt <= cycle_cnt + 1;

    // step result is a one-cycle pulse
    assert property (@(posedge ep50trig) disable iff (reset_global)
                     o_step_valid |=> !o_step_valid)
    else
    begin
        err_cnt++;
        $display("o_step_valid stayed high for two cycles at cycle %0d", cycle_cnt);
    end

    assert property (@(posedge ep50trig) disable iff (reset_global)
                     o_feed_done |=> o_feed_done)
    else
    begin
        err_cnt++;
        $display("o_feed_done dropped without a reset at cycle %0d", cycle_cnt);
    end

    initial
    begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("run stopped after %0d cycles, steps no longer complete", cycle_cnt);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // checks and reporting
    ////////////////////////////////////////////////////////////
    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        bit ok;
        ok = (got === exp);
        check_cnt++;
        assert (ok)
        else
            $display("Error: %s is %0h, expected %0h (cycle %0d)", name, got, exp, cycle_cnt);
        if (!ok)
            err_cnt++;
    endtask

    task automatic expect_true(input bit cond, input string what);
        check_cnt++;
        assert (cond)
        else
            $display("%s (cycle %0d)", what, cycle_cnt);
        if (!cond)
            err_cnt++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = err_cnt;
    endtask

    task automatic finish_test();
        test_cnt++;
        if (err_cnt == test_err0)
            $display("test %0d %s: pass", test_cnt, test_name);
        else
        begin
            fail_cnt++;
            $display("test %0d %s: FAIL, %0d errors", test_cnt, test_name, err_cnt - test_err0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // neuron rules, one pass per step
    ////////////////////////////////////////////////////////////
    task automatic update_neuron(input int idx, input longint drive, output bit fired);
        longint acc;
        acc = v_exp[idx] - (v_exp[idx] >>> leak_m) + drive;
        if (acc > V_MAX)
            acc = V_MAX;
        else if (acc < V_MIN)
            acc = V_MIN;
        fired      = (acc >= thresh_m);
        v_exp[idx] = fired ? 64'sd0 : acc;      // back to rest on a spike
    endtask

    task automatic check_step();
        longint drive_ia;
        longint drive_ii;
        if (play_on)
        begin
            smp_exp  = wave[play_idx];
            play_idx = (play_idx + 1) % wave.size();
        end
        drive_ia = (longint'(smp_exp) * coef_ia_m) >>> 8;
        drive_ii = (longint'(smp_exp) * coef_ii_m) >>> 8;
        update_neuron(0, drive_ia, ia_exp);
        update_neuron(1, drive_ii, ii_exp);
        update_neuron(2, ia_exp ? gain_mn_m : 64'sd0, mn_exp);   // same-pass Ia only
        if (mn_exp)
            mn_total++;
        ia_seen = ia_seen + o_ia_spike;
        ii_seen = ii_seen + o_ii_spike;
        mn_seen = mn_seen + o_mn_spike;
        compare_value("o_sample", o_sample, smp_exp);
        compare_value("o_ia_spike", o_ia_spike, ia_exp);
        compare_value("o_ii_spike", o_ii_spike, ii_exp);
        compare_value("o_mn_spike", o_mn_spike, mn_exp);
        compare_value("o_mn_count", o_mn_count, mn_total);
    endtask

    task automatic reset_model(input bit global);
        v_exp[0] = 0;
        v_exp[1] = 0;
        v_exp[2] = 0;
        smp_exp  = '0;
        play_idx = 0;
        if (global)
        begin
            play_on   = 1'b0;
            wave.delete();
            mn_total  = 0;
            coef_ia_m = `SR_COEF_IA_DEF;
            coef_ii_m = `SR_COEF_II_DEF;
            gain_mn_m = `SR_GAIN_MN_DEF;
            thresh_m  = `SR_THRESH_DEF;
            leak_m    = `SR_LEAK_DEF;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus, all on the falling edge
    ////////////////////////////////////////////////////////////
    task automatic tick();
        @(negedge ep50trig);
        if (!reset_global && o_step_valid)
        begin
            step_gap      = cycle_cnt - last_step_cyc;
            last_step_cyc = cycle_cnt;
            check_step();
        end
    endtask

    task automatic wait_step();
        tick();
        while (reset_global || !o_step_valid)
            tick();
    endtask

    task automatic load_param(input int bit_no, input logic [31:0] value);
        i_trig                 = '0;
        i_trig[bit_no]         = 1'b1;
        {i_wire_hi, i_wire_lo} = value;
        tick();
        i_trig = '0;
        case (bit_no)
            `SR_TRIG_COEF_IA:   coef_ia_m = value;
            `SR_TRIG_COEF_II:   coef_ii_m = value;
            `SR_TRIG_GAIN_MN:   gain_mn_m = value;
            `SR_TRIG_THRESH:    thresh_m  = value;
            `SR_TRIG_LEAK:      leak_m    = value;
            `SR_TRIG_CNT_CLEAR: mn_total  = 0;
            default: ;
        endcase
    endtask

    task automatic fill_wave(input int n, input bit rand_data);
        for (int i = 0; i < n; i++)
        begin
            i_pipe_data  = rand_data ? 16'($urandom) : BIG_SAMPLE;
            i_pipe_write = 1'b1;
            wave.push_back(i_pipe_data);
            tick();
        end
        i_pipe_write = 1'b0;
        tick();
        play_on = 1'b1;
    endtask

    initial
    begin
        rst_req      = 1'b0;
        i_sim_reset  = 1'b0;
        i_trig       = '0;
        i_wire_lo    = '0;
        i_wire_hi    = '0;
        i_pipe_write = 1'b0;
        i_pipe_data  = '0;
        void'($urandom(SEED));
        reset_model(1'b1);

        start_test("step period");
        wait_step();
        wait_step();
        compare_value("o_step_valid spacing", step_gap, 32);
        wait_step();
        compare_value("o_step_valid spacing", step_gap, 32);
        load_param(`SR_TRIG_PERIOD, 32'd20);
        wait_step();                            // old period still running
        wait_step();
        compare_value("o_step_valid spacing", step_gap, 20);
        wait_step();
        compare_value("o_step_valid spacing", step_gap, 20);
        load_param(`SR_TRIG_PERIOD, 32'd5);
        wait_step();
        wait_step();
        compare_value("o_step_valid spacing", step_gap, `SR_PERIOD_MIN);
        wait_step();
        compare_value("o_step_valid spacing", step_gap, `SR_PERIOD_MIN);
        finish_test();

        start_test("waveform playback");
        load_param(`SR_TRIG_PERIOD, 32'd32);
        wait_step();
        compare_value("o_feed_done", o_feed_done, 0);
        fill_wave(10, 1'b1);
        compare_value("o_feed_done", o_feed_done, 1);
        repeat (12) wait_step();                // one full lap and the wrap
        i_sim_reset = 1'b1;
        tick();
        i_sim_reset = 1'b0;
        reset_model(1'b0);
        repeat (3) wait_step();
        finish_test();

        start_test("afferent spikes");
        rst_req = 1'b1;
        tick();
        rst_req = 1'b0;
        reset_model(1'b1);
        while (reset_global)
            tick();
        fill_wave(1, 1'b0);
        ia_seen = 0;
        ii_seen = 0;
        mn_seen = 0;
        repeat (9) wait_step();
        expect_true(ii_seen > 0, "II afferent never fired at the large sample");
        expect_true(ia_seen > ii_seen, "Ia afferent did not fire more often than II");
        finish_test();

        start_test("motoneuron drive");
        repeat (4) wait_step();
        expect_true(mn_seen > 0, "motoneuron never fired with the default gain");
        load_param(`SR_TRIG_GAIN_MN, 32'd0);
        mn_seen = 0;
        repeat (6) wait_step();
        expect_true(mn_seen == 0, "motoneuron fired with gain_mn at zero");
        finish_test();

        start_test("spike count");
        expect_true(o_mn_count != 0, "no motoneuron spikes counted before the clear");
        load_param(`SR_TRIG_CNT_CLEAR, 32'd0);
        compare_value("o_mn_count", o_mn_count, 0);
        load_param(`SR_TRIG_GAIN_MN, `SR_GAIN_MN_DEF);
        mn_seen = 0;
        repeat (7) wait_step();
        expect_true(mn_seen > 0, "motoneuron did not fire again after the clear");
        compare_value("o_mn_count", o_mn_count, mn_total);
        finish_test();

        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, test_cnt - fail_cnt, fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- stretch_reflex.f
+incdir+verilog
verilog/stretch_reflex_pkg.sv
verilog/neuron_if.sv
verilog/param_regs.sv
verilog/step_timer.sv
verilog/waveform_buffer.sv
verilog/neuron_seq.sv
verilog/neuron_core.sv
verilog/stretch_reflex_top.sv
dv/tb_clkgen.sv
dv/tb_stretch_reflex.sv

//--- verilog/neuron_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "stretch_reflex_consts.svh"

module neuron_core
(
    input  wire                             ep50trig,
    input  wire                             reset_global,
    input  wire                             i_sim_reset,
    input  wire                             i_cnt_clear,
    input  wire [`SR_WORD_W-1:0]            i_sample,
    input  stretch_reflex_pkg::param_bank_t i_params,
    neuron_if.core                          nif,
    output logic                            o_ia_spike,
    output logic                            o_ii_spike,
    output logic                            o_mn_spike,
    output logic [`SR_PARAM_W-1:0]          o_mn_count,
    output logic                            o_step_valid
);
    import stretch_reflex_pkg::*;

    localparam int ACC_W  = 52;             // product plus headroom
    localparam int PROD_W = `SR_WORD_W + `SR_PARAM_W;

    logic signed [`SR_V_W-1:0] v_mem [0:2];
    logic signed [`SR_V_W-1:0] v_rd;
    logic signed [`SR_V_W-1:0] v_new_q;
    logic signed [`SR_V_W-1:0] v_sat;
    logic [2:0]                spk_pass;    // this pass, indexed by neuron_id
    logic [PROD_W-1:0]         prod_ia;
    logic [PROD_W-1:0]         prod_ii;
    logic [ACC_W-1:0]          drive;
    logic signed [ACC_W-1:0]   v_ext;
    logic signed [ACC_W-1:0]   acc;
    logic signed [ACC_W-1:0]   thresh_ext;
    logic                      spike;
    logic                      rd_en;
    logic                      upd_en;
    logic                      wr_en;

    assign rd_en  = nif.busy && (nif.phase == READ);
    assign upd_en = nif.busy && (nif.phase == UPDATE);
    assign wr_en  = nif.busy && (nif.phase == WRITE);

    ////////////////////////////////////////////////////////////
    // update datapath
    ////////////////////////////////////////////////////////////
    assign prod_ia = i_sample * i_params.coef_ia;
    assign prod_ii = i_sample * i_params.coef_ii;

    always_comb
    begin
        case (nif.neuron_id)
            NEU_IA:  drive = ACC_W'(prod_ia >> 8);
            NEU_II:  drive = ACC_W'(prod_ii >> 8);
            NEU_MN:  drive = spk_pass[NEU_IA] ? ACC_W'(i_params.gain_mn) : '0;
            default: drive = '0;
        endcase
    end

    assign v_ext = {{(ACC_W-`SR_V_W){v_rd[`SR_V_W-1]}}, v_rd};
    assign acc   = v_ext - (v_ext >>> i_params.leak_shift) + $signed(drive);

    // clamp to the signed potential range
    always_comb
    begin
        if (acc[ACC_W-1:`SR_V_W-1] == '0 || acc[ACC_W-1:`SR_V_W-1] == '1)
            v_sat = acc[`SR_V_W-1:0];
        else if (acc[ACC_W-1])
            v_sat = {1'b1, {(`SR_V_W-1){1'b0}}};
        else
            v_sat = {1'b0, {(`SR_V_W-1){1'b1}}};
    end

    assign thresh_ext = $signed({{(ACC_W-`SR_PARAM_W){1'b0}}, i_params.threshold});
    assign spike      = ($signed({{(ACC_W-`SR_V_W){v_sat[`SR_V_W-1]}}, v_sat}) >= thresh_ext);

    always_ff @(posedge ep50trig)
    begin
        if (rd_en)
            v_rd <= v_mem[nif.neuron_id];
        if (upd_en)
            v_new_q <= spike ? '0 : v_sat;  // fire and reset to rest
    end

    // potential memory and per-pass spike flags
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_sim_reset)
        begin
            v_mem[NEU_IA] <= '0;
            v_mem[NEU_II] <= '0;
            v_mem[NEU_MN] <= '0;
            spk_pass      <= '0;
        end
        else
        begin
            if (upd_en)
                spk_pass[nif.neuron_id] <= spike;
            if (wr_en)
                v_mem[nif.neuron_id] <= v_new_q;
        end
    end

    ////////////////////////////////////////////////////////////
    // step results
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            o_ia_spike   <= 1'b0;
            o_ii_spike   <= 1'b0;
            o_mn_spike   <= 1'b0;
            o_mn_count   <= '0;
            o_step_valid <= 1'b0;
        end
        else
        begin
            o_step_valid <= nif.step_done;  // lines up with the new flags
            if (i_sim_reset)
            begin
                o_ia_spike <= 1'b0;
                o_ii_spike <= 1'b0;
                o_mn_spike <= 1'b0;
            end
            else if (nif.step_done)
            begin
                o_ia_spike <= spk_pass[NEU_IA];
                o_ii_spike <= spk_pass[NEU_II];
                o_mn_spike <= spk_pass[NEU_MN];
            end
            if (i_cnt_clear)
                o_mn_count <= '0;
            else if (nif.step_done && spk_pass[NEU_MN])
                o_mn_count <= o_mn_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/neuron_if.sv
`timescale 1ns/1ps
`default_nettype none

// sequencer to neuron core control bundle
interface neuron_if;
    import stretch_reflex_pkg::*;

    neuron_id_t neuron_id;   // which neuron is in flight
    seq_state_t phase;       // read / update / write / done
    logic       busy;        // pass in progress
    logic       step_done;   // one cycle, end of pass

    modport seq
    (
        output neuron_id,
        output phase,
        output busy,
        output step_done
    );

    modport core
    (
        input neuron_id,
        input phase,
        input busy,
        input step_done
    );

endinterface

`default_nettype wire

//--- verilog/neuron_seq.sv
`timescale 1ns/1ps
`default_nettype none

module neuron_seq
(
    input  wire     ep50trig,
    input  wire     reset_global,
    input  wire     i_sim_reset,
    input  wire     i_step,
    neuron_if.seq   nif
);
    import stretch_reflex_pkg::*;

    seq_state_t state;
    neuron_id_t nid;
    logic       step_q;     // lets the new sample settle first

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_sim_reset)
        begin
            step_q <= 1'b0;
            state  <= IDLE;
            nid    <= NEU_IA;
        end
        else
        begin
            step_q <= i_step;
            case (state)
                IDLE:
                begin
                    if (step_q)
                    begin
                        state <= READ;
                        nid   <= NEU_IA;
                    end
                end
                READ:   state <= UPDATE;
                UPDATE: state <= WRITE;
                WRITE:
                begin
                    if (nid == NEU_MN)
                        state <= DONE;
                    else
                    begin
                        state <= READ;
                        nid   <= neuron_id_t'(nid + 1'b1);  // Ia, II, MN
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign nif.neuron_id = nid;
    assign nif.phase     = state;
    assign nif.busy      = (state == READ) || (state == UPDATE) || (state == WRITE);
    assign nif.step_done = (state == DONE);

endmodule

`default_nettype wire

//--- verilog/param_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "stretch_reflex_consts.svh"

module param_regs
(
    input  wire                            ep50trig,
    input  wire                            reset_global,
    input  wire [15:0]                     i_trig,
    input  wire [`SR_WORD_W-1:0]           i_wire_lo,
    input  wire [`SR_WORD_W-1:0]           i_wire_hi,
    output stretch_reflex_pkg::param_bank_t o_params
);
    import stretch_reflex_pkg::*;

    logic [`SR_PARAM_W-1:0] host_word;

    assign host_word = {i_wire_hi, i_wire_lo};  // 32-bit word from two wires

    ////////////////////////////////////////////////////////////
    // one register per trigger bit
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            o_params.period     <= `SR_PARAM_W'(`SR_PERIOD_DEF);
            o_params.coef_ia    <= `SR_PARAM_W'(`SR_COEF_IA_DEF);
            o_params.coef_ii    <= `SR_PARAM_W'(`SR_COEF_II_DEF);
            o_params.gain_mn    <= `SR_PARAM_W'(`SR_GAIN_MN_DEF);
            o_params.threshold  <= `SR_PARAM_W'(`SR_THRESH_DEF);
            o_params.leak_shift <= `SR_PARAM_W'(`SR_LEAK_DEF);
        end
        else
        begin
            if (i_trig[`SR_TRIG_PERIOD])
                o_params.period <= host_word;
            if (i_trig[`SR_TRIG_COEF_IA])
                o_params.coef_ia <= host_word;
            if (i_trig[`SR_TRIG_COEF_II])
                o_params.coef_ii <= host_word;
            if (i_trig[`SR_TRIG_GAIN_MN])
                o_params.gain_mn <= host_word;
            if (i_trig[`SR_TRIG_THRESH])
                o_params.threshold <= host_word;
            if (i_trig[`SR_TRIG_LEAK])
                o_params.leak_shift <= host_word;   // shift count, not a ratio
        end
    end

endmodule

`default_nettype wire

//--- verilog/step_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "stretch_reflex_consts.svh"

module step_timer
(
    input  wire                   ep50trig,
    input  wire                   reset_global,
    input  wire                   i_sim_reset,
    input  wire [`SR_PARAM_W-1:0] i_period,
    output logic                  o_step
);

    logic [`SR_PARAM_W-1:0] period_eff;
    logic [`SR_PARAM_W-1:0] cnt;

    // floor keeps a full neuron pass inside one step
    assign period_eff = (i_period < `SR_PARAM_W'(`SR_PERIOD_MIN)) ?
                        `SR_PARAM_W'(`SR_PERIOD_MIN) : i_period;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_sim_reset)
        begin
            cnt    <= period_eff - 1'b1;
            o_step <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt    <= period_eff - 1'b1;  // new period applies from here
            o_step <= 1'b1;
        end
        else
        begin
            cnt    <= cnt - 1'b1;
            o_step <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/stretch_reflex_consts.svh
`ifndef STRETCH_REFLEX_CONSTS_SVH
`define STRETCH_REFLEX_CONSTS_SVH

// datapath widths
`define SR_WORD_W         16    // host wire and waveform sample
`define SR_PARAM_W        32    // one parameter word, {wire_hi, wire_lo}
`define SR_PIPE_DEPTH     64    // waveform entries
`define SR_V_W            18    // signed neuron potential

// bit numbers on the host trigger bus
`define SR_TRIG_COEF_IA   1
`define SR_TRIG_COEF_II   2
`define SR_TRIG_THRESH    4
`define SR_TRIG_LEAK      5
`define SR_TRIG_GAIN_MN   6
`define SR_TRIG_PERIOD    7
`define SR_TRIG_CNT_CLEAR 8

// parameter values after reset_global
`define SR_PERIOD_DEF     32
`define SR_COEF_IA_DEF    256
`define SR_COEF_II_DEF    128
`define SR_GAIN_MN_DEF    4096
`define SR_THRESH_DEF     16384
`define SR_LEAK_DEF       3

// shortest step, long enough for a full neuron pass
`define SR_PERIOD_MIN     16

`endif

//--- verilog/stretch_reflex_pkg.sv
`default_nettype none

`include "stretch_reflex_consts.svh"

package stretch_reflex_pkg;

    // processing order, doubles as the state memory address
    typedef enum logic [1:0]
    {
        NEU_IA = 2'd0,
        NEU_II = 2'd1,
        NEU_MN = 2'd2
    } neuron_id_t;

    // sequencer phases
    typedef enum logic [2:0]
    {
        IDLE   = 3'd0,
        READ   = 3'd1,
        UPDATE = 3'd2,
        WRITE  = 3'd3,
        DONE   = 3'd4
    } seq_state_t;

    // host loaded model parameters
    typedef struct packed
    {
        logic [`SR_PARAM_W-1:0] period;     // cycles per step
        logic [`SR_PARAM_W-1:0] coef_ia;    // sample gain into Ia, 8 fraction bits
        logic [`SR_PARAM_W-1:0] coef_ii;    // sample gain into II, 8 fraction bits
        logic [`SR_PARAM_W-1:0] gain_mn;    // Ia spike to MN drive
        logic [`SR_PARAM_W-1:0] threshold;
        logic [`SR_PARAM_W-1:0] leak_shift;
    } param_bank_t;

endpackage

`default_nettype wire

//--- verilog/stretch_reflex_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "stretch_reflex_consts.svh"

module stretch_reflex_top
(
    input  wire                    ep50trig,
    input  wire                    reset_global,
    input  wire                    i_sim_reset,
    input  wire [15:0]             i_trig,
    input  wire [`SR_WORD_W-1:0]   i_wire_lo,
    input  wire [`SR_WORD_W-1:0]   i_wire_hi,
    input  wire                    i_pipe_write,
    input  wire [`SR_WORD_W-1:0]   i_pipe_data,
    output wire [`SR_WORD_W-1:0]   o_sample,
    output wire                    o_feed_done,
    output wire                    o_step_valid,
    output wire                    o_ia_spike,
    output wire                    o_ii_spike,
    output wire                    o_mn_spike,
    output wire [`SR_PARAM_W-1:0]  o_mn_count
);
    import stretch_reflex_pkg::*;

    param_bank_t params;
    logic        step;

    neuron_if nif ();

    param_regs u_param_regs
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_wire_lo    (i_wire_lo),
        .i_wire_hi    (i_wire_hi),
        .o_params     (params)
    );

    step_timer u_step_timer
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_period     (params.period),
        .o_step       (step)
    );

    waveform_buffer u_waveform_buffer
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_pipe_write (i_pipe_write),
        .i_pipe_data  (i_pipe_data),
        .i_step       (step),
        .o_sample     (o_sample),
        .o_feed_done  (o_feed_done)
    );

    neuron_seq u_neuron_seq
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_step       (step),
        .nif          (nif.seq)
    );

    neuron_core u_neuron_core
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_cnt_clear  (i_trig[`SR_TRIG_CNT_CLEAR]),   // straight from the host
        .i_sample     (o_sample),
        .i_params     (params),
        .nif          (nif.core),
        .o_ia_spike   (o_ia_spike),
        .o_ii_spike   (o_ii_spike),
        .o_mn_spike   (o_mn_spike),
        .o_mn_count   (o_mn_count),
        .o_step_valid (o_step_valid)
    );

endmodule

`default_nettype wire

//--- verilog/waveform_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "stretch_reflex_consts.svh"

module waveform_buffer
(
    input  wire                   ep50trig,
    input  wire                   reset_global,
    input  wire                   i_sim_reset,
    input  wire                   i_pipe_write,
    input  wire [`SR_WORD_W-1:0]  i_pipe_data,
    input  wire                   i_step,
    output logic [`SR_WORD_W-1:0] o_sample,
    output logic                  o_feed_done
);

    localparam int PTR_W = $clog2(`SR_PIPE_DEPTH);
    localparam int CNT_W = PTR_W + 1;       // room for a full buffer count

    logic [`SR_WORD_W-1:0] mem [0:`SR_PIPE_DEPTH-1];
    logic [CNT_W-1:0]      wr_ptr;
    logic [CNT_W-1:0]      len;             // entries played per lap
    logic [PTR_W-1:0]      rd_ptr;
    logic                  wr_en;

    assign wr_en = i_pipe_write && (wr_ptr < CNT_W'(`SR_PIPE_DEPTH));

    always_ff @(posedge ep50trig)
    begin
        if (wr_en)
            mem[wr_ptr[PTR_W-1:0]] <= i_pipe_data;
    end

    ////////////////////////////////////////////////////////////
    // host side fill
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            wr_ptr      <= '0;
            len         <= '0;
            o_feed_done <= 1'b0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;   // extra writes past depth dropped
            if (!i_pipe_write && wr_ptr != '0)
            begin
                o_feed_done <= 1'b1;
                len         <= wr_ptr;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // playback, one sample per step
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_sim_reset)
        begin
            rd_ptr   <= '0;
            o_sample <= '0;
        end
        else if (i_step && o_feed_done)
        begin
            o_sample <= mem[rd_ptr];
            if ({1'b0, rd_ptr} == len - 1'b1)
                rd_ptr <= '0;               // lap done
            else
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire
